/* rtl/fabric_pkg.sv */
package fabric_pkg;

  // Row of logic tiles
  localparam int NUM_TILES  = 4;
  // Fabric input bits shared by every tile
  localparam int NUM_FAB_IN = 4;

  // LUT geometry
  localparam int LUT_K    = 4;
  localparam int LUT_SIZE = 1 << LUT_K;

  // Router select width
  // Sources 0..3 are fabric inputs, 4..7 are tile outputs
  localparam int SRC_W   = 3;
  localparam int NUM_SRC = 1 << SRC_W;

  // Configuration bits held by one tile
  localparam int CFG_W = 32;

  // Serial load counts one bit per cycle
  localparam int BIT_CNT_W = $clog2(CFG_W);

  // Leftover bits at the top of the word
  localparam int SPARE_W = CFG_W - 1 - LUT_K * SRC_W - LUT_SIZE;

  // Tile configuration word
  // Shifted as raw bits, decoded by the logic cell through fld
  typedef union packed {
    logic [CFG_W-1:0] raw;
    struct packed {
      // Not decoded
      logic [SPARE_W-1:0]             spare;
      // Tile output taken from the flip-flop
      logic                           ff_en;
      // One source select per LUT input, sel[3] highest
      logic [LUT_K-1:0][SRC_W-1:0]    sel;
      // Truth table, routed input 0 is the index LSB
      logic [LUT_SIZE-1:0]            lut_init;
    } fld;
  } tile_cfg_u;

endpackage

/* rtl/wb_map_pkg.sv */
package wb_map_pkg;

  // Bus widths
  localparam int WB_DW = 32;
  localparam int WB_AW = 32;
  localparam int WB_SW = WB_DW / 8;

  // Registers are word aligned, only a 16-byte window is decoded
  localparam int ADR_LSB   = 2;
  localparam int REG_OFS_W = 4;

  // Register byte offsets
  localparam logic [REG_OFS_W-1:0] REG_CFG_DATA = 4'h0;
  localparam logic [REG_OFS_W-1:0] REG_CTRL     = 4'h4;
  localparam logic [REG_OFS_W-1:0] REG_FAB_IN   = 4'h8;
  localparam logic [REG_OFS_W-1:0] REG_FAB_OUT  = 4'hC;

  // CTRL bit positions
  localparam int CTRL_EN_BIT   = 0;
  localparam int CTRL_SET_BIT  = 1;
  localparam int CTRL_BUSY_BIT = 8;

  // Slave handshake states
  localparam int              ST_W    = 2;
  localparam logic [ST_W-1:0] ST_IDLE = 2'd0;
  localparam logic [ST_W-1:0] ST_ACK  = 2'd1;
  localparam logic [ST_W-1:0] ST_WAIT = 2'd2;

endpackage

/* rtl/wb_config_ctrl.sv */
`timescale 1ns/1ns

module wb_config_ctrl (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  // Wishbone classic slave
  input  logic                              wbs_cyc_i,
  input  logic                              wbs_stb_i,
  input  logic                              wbs_we_i,
  input  logic [wb_map_pkg::WB_SW-1:0]      wbs_sel_i,
  input  logic [wb_map_pkg::WB_AW-1:0]      wbs_adr_i,
  input  logic [wb_map_pkg::WB_DW-1:0]      wbs_dat_i,
  output logic                              wbs_ack_o,
  output logic [wb_map_pkg::WB_DW-1:0]      wbs_dat_o,
  // Tile outputs for readback
  input  logic [fabric_pkg::NUM_TILES-1:0]  fab_out_i,
  // Configuration chain control
  output logic                              cfg_bit_o,
  output logic                              cfg_shift_o,
  output logic                              cfg_set_o,
  output logic                              fab_en_o,
  output logic [fabric_pkg::NUM_FAB_IN-1:0] fab_in_o
);
  import wb_map_pkg::*;
  import fabric_pkg::*;

  // Handshake FSM
  logic [ST_W-1:0]      state_q;
  logic [ST_W-1:0]      state_d;

  // Decode of the current request
  logic [REG_OFS_W-1:0] reg_ofs;
  logic                 req;
  logic                 wr;
  logic                 wr_cfg;
  logic                 wr_ctrl;
  logic                 wr_fab_in;
  logic                 want_set;
  logic                 blocked;
  logic                 accept;

  // Control registers
  logic                 en_q;
  logic                 set_q;
  logic [NUM_FAB_IN-1:0] fab_in_q;

  // Serial shift engine
  logic                 busy_q;
  logic [BIT_CNT_W-1:0] cnt_q;
  logic [CFG_W-1:0]     shreg_q;

  // Byte lanes dropped, every access is a full word
  assign reg_ofs = {wbs_adr_i[REG_OFS_W-1:ADR_LSB], {ADR_LSB{1'b0}}};

  assign req       = wbs_cyc_i & wbs_stb_i;
  assign wr        = req & wbs_we_i;
  assign wr_cfg    = wr & (reg_ofs == REG_CFG_DATA);
  assign wr_ctrl   = wr & (reg_ofs == REG_CTRL);
  assign wr_fab_in = wr & (reg_ofs == REG_FAB_IN);
  assign want_set  = wr_ctrl & wbs_dat_i[CTRL_SET_BIT];

  // Back-pressure
  // New word or set must wait for the chain to settle
  assign blocked = busy_q & (wr_cfg | want_set);
  assign accept  = (state_q == ST_IDLE) & req & ~blocked;

  // Idle, one ack cycle, then hold until the master drops stb
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (accept) begin
          state_d = ST_ACK;
        end
      end
      ST_ACK: begin
        state_d = wbs_stb_i ? ST_WAIT : ST_IDLE;
      end
      ST_WAIT: begin
        if (!wbs_stb_i) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= ST_IDLE;
      en_q     <= 1'b0;
      set_q    <= 1'b0;
      fab_in_q <= '0;
    end else begin
      state_q <= state_d;
      // Set lasts exactly the ack cycle
      set_q   <= accept & want_set;
      if (accept & wr_ctrl) begin
        en_q <= wbs_dat_i[CTRL_EN_BIT];
      end
      if (accept & wr_fab_in) begin
        fab_in_q <= wbs_dat_i[NUM_FAB_IN-1:0];
      end
    end
  end

  // Busy for CFG_W cycles after a word is taken
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (accept & wr_cfg) begin
      busy_q <= 1'b1;
      cnt_q  <= '0;
    end else if (busy_q) begin
      cnt_q <= cnt_q + 1'b1;
      // Last bit goes out this cycle
      if (cnt_q == BIT_CNT_W'(CFG_W - 1)) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Word register, MSB leaves first
  always_ff @(posedge clk_i) begin
    if (accept & wr_cfg) begin
      shreg_q <= wbs_dat_i;
    end else if (busy_q) begin
      shreg_q <= {shreg_q[CFG_W-2:0], 1'b0};
    end
  end

  // Read mux, valid while ack is high
  always_comb begin
    wbs_dat_o = '0;
    case (reg_ofs)
      REG_CTRL: begin
        wbs_dat_o[CTRL_EN_BIT]   = en_q;
        wbs_dat_o[CTRL_BUSY_BIT] = busy_q;
      end
      REG_FAB_IN: begin
        wbs_dat_o[NUM_FAB_IN-1:0] = fab_in_q;
      end
      REG_FAB_OUT: begin
        wbs_dat_o[NUM_TILES-1:0] = fab_out_i;
      end
      // CFG_DATA is write only
      default: begin
        wbs_dat_o = '0;
      end
    endcase
  end

  assign wbs_ack_o   = (state_q == ST_ACK);
  assign cfg_bit_o   = shreg_q[CFG_W-1];
  assign cfg_shift_o = busy_q;
  assign cfg_set_o   = set_q;
  assign fab_en_o    = en_q;
  assign fab_in_o    = fab_in_q;

endmodule

/* rtl/config_segment.sv */
`timescale 1ns/1ns

module config_segment (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  shift_i,
  input  logic                  set_i,
  // Serial chain
  input  logic                  bit_i,
  output logic                  bit_o,
  // Active configuration of this tile
  output fabric_pkg::tile_cfg_u cfg_o
);
  import fabric_pkg::*;

  // Shadow bits, loaded serially
  logic [CFG_W-1:0] shadow_q;
  // Bits the tile runs from
  tile_cfg_u        active_q;

  // Left shift, new bit enters at the bottom
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      shadow_q <= '0;
    end else if (shift_i) begin
      shadow_q <= {shadow_q[CFG_W-2:0], bit_i};
    end
  end

  // Copy on set so reloading does not disturb running logic
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      active_q <= '0;
    end else if (set_i) begin
      active_q.raw <= shadow_q;
    end
  end

  // Top bit feeds the next tile
  assign bit_o = shadow_q[CFG_W-1];
  assign cfg_o = active_q;

endmodule

/* rtl/logic_cell.sv */
`timescale 1ns/1ns

module logic_cell (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  // Flip-flop load enable
  input  logic                              en_i,
  input  fabric_pkg::tile_cfg_u             cfg_i,
  // Routing sources
  input  logic [fabric_pkg::NUM_FAB_IN-1:0] fab_in_i,
  input  logic [fabric_pkg::NUM_TILES-1:0]  tile_out_i,
  output logic                              out_o
);
  import fabric_pkg::*;

  // All eight router sources
  logic [NUM_SRC-1:0] src;
  // Routed LUT inputs
  logic [LUT_K-1:0]   lut_idx;
  logic               lut_out;
  logic               ff_q;

  // Fabric inputs low, tile outputs high
  assign src = {tile_out_i, fab_in_i};

  // One 8:1 mux per LUT input
  always_comb begin
    for (int k = 0; k < LUT_K; k++) begin
      lut_idx[k] = src[cfg_i.fld.sel[k]];
    end
  end

  // Truth table lookup
  assign lut_out = cfg_i.fld.lut_init[lut_idx];

  // Output register, holds while the fabric is disabled
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ff_q <= 1'b0;
    end else if (en_i) begin
      ff_q <= lut_out;
    end
  end

  // Registered or direct
  assign out_o = cfg_i.fld.ff_en ? ff_q : lut_out;

endmodule

/* rtl/fabric_top.sv */
`timescale 1ns/1ns

module fabric_top (
  input  logic                             wb_clk_i,
  input  logic                             rst_n_i,
  // Wishbone classic slave
  input  logic                             wbs_cyc_i,
  input  logic                             wbs_stb_i,
  input  logic                             wbs_we_i,
  input  logic [wb_map_pkg::WB_SW-1:0]     wbs_sel_i,
  input  logic [wb_map_pkg::WB_AW-1:0]     wbs_adr_i,
  input  logic [wb_map_pkg::WB_DW-1:0]     wbs_dat_i,
  output logic                             wbs_ack_o,
  output logic [wb_map_pkg::WB_DW-1:0]     wbs_dat_o,
  // Tile outputs
  output logic [fabric_pkg::NUM_TILES-1:0] fab_out_o
);
  import fabric_pkg::*;

  // Broadcast from the configurator
  logic                  cfg_bit;
  logic                  cfg_shift;
  logic                  cfg_set;
  logic                  fab_en;
  logic [NUM_FAB_IN-1:0] fab_in;

  // Chain taps, seg_out of the last tile is the chain tail
  logic [NUM_TILES-1:0]  seg_in;
  logic [NUM_TILES-1:0]  seg_out;

  // Per-tile active configuration
  tile_cfg_u             tile_cfg [NUM_TILES];
  logic [NUM_TILES-1:0]  tile_out;

  wb_config_ctrl u_ctrl (
    .clk_i       (wb_clk_i),
    .rst_n_i     (rst_n_i),
    .wbs_cyc_i   (wbs_cyc_i),
    .wbs_stb_i   (wbs_stb_i),
    .wbs_we_i    (wbs_we_i),
    .wbs_sel_i   (wbs_sel_i),
    .wbs_adr_i   (wbs_adr_i),
    .wbs_dat_i   (wbs_dat_i),
    .wbs_ack_o   (wbs_ack_o),
    .wbs_dat_o   (wbs_dat_o),
    .fab_out_i   (tile_out),
    .cfg_bit_o   (cfg_bit),
    .cfg_shift_o (cfg_shift),
    .cfg_set_o   (cfg_set),
    .fab_en_o    (fab_en),
    .fab_in_o    (fab_in)
  );

  // Tile 0 takes the serial bit, each later tile the previous top bit
  assign seg_in = {seg_out[NUM_TILES-2:0], cfg_bit};

  genvar g;
  generate
    for (g = 0; g < NUM_TILES; g = g + 1) begin : g_tile
      config_segment u_seg (
        .clk_i   (wb_clk_i),
        .rst_n_i (rst_n_i),
        .shift_i (cfg_shift),
        .set_i   (cfg_set),
        .bit_i   (seg_in[g]),
        .bit_o   (seg_out[g]),
        .cfg_o   (tile_cfg[g])
      );

      logic_cell u_cell (
        .clk_i      (wb_clk_i),
        .rst_n_i    (rst_n_i),
        .en_i       (fab_en),
        .cfg_i      (tile_cfg[g]),
        .fab_in_i   (fab_in),
        .tile_out_i (tile_out),
        .out_o      (tile_out[g])
      );
    end
  endgenerate

  assign fab_out_o = tile_out;

endmodule

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD_NS = 10
) (
  output logic clk_o
);

  // Free running, starts low
  initial begin
    clk_o = 1'b0;
  end

  always begin
    #(PERIOD_NS / 2);
    clk_o = ~clk_o;
  end

endmodule

/* verif/tb_fabric_top.sv */
`timescale 1ns/1ns

module tb_fabric_top;
  import wb_map_pkg::*;
  import fabric_pkg::*;

  // Run limit, tests need about 1500 cycles
  localparam int MAX_CYCLES = 4000;

  logic        clk;
  logic        rst_n_i;
  logic        wbs_cyc_i;
  logic        wbs_stb_i;
  logic        wbs_we_i;
  logic [3:0]  wbs_sel_i;
  logic [31:0] wbs_adr_i;
  logic [31:0] wbs_dat_i;
  logic        wbs_ack_o;
  logic [31:0] wbs_dat_o;
  logic [3:0]  fab_out_o;

  // Expected shadow and active words per tile
  logic [31:0] shadow_m [4];
  logic [31:0] active_m [4];
  logic        en_m;
  logic [15:0] lfsr_q;
  int          cycle_cnt;
  int          ack_wait;

  tb_clk_gen #(.PERIOD_NS(10)) u_clk (.clk_o(clk));

  fabric_top uut (
    .wb_clk_i  (clk),
    .rst_n_i   (rst_n_i),
    .wbs_cyc_i (wbs_cyc_i),
    .wbs_stb_i (wbs_stb_i),
    .wbs_we_i  (wbs_we_i),
    .wbs_sel_i (wbs_sel_i),
    .wbs_adr_i (wbs_adr_i),
    .wbs_dat_i (wbs_dat_i),
    .wbs_ack_o (wbs_ack_o),
    .wbs_dat_o (wbs_dat_o),
    .fab_out_o (fab_out_o)
  );

  // Hang guard
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: run went past %0d clock cycles", MAX_CYCLES);
      $display("Checks failed");
      $fatal(1);
    end
  end

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic next_bit();
    logic fb;
    fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], next_bit()};
    end
    return r;
  endfunction

  // ff_en 0, every select on a fabric input
  function automatic logic [31:0] comb_word();
    logic [31:0] w;
    w = '0;
    for (int k = 0; k < 4; k++) begin
      w[16 + 3 * k +: 3] = {1'b0, 2'(rand_bits(2))};
    end
    w[15:0] = 16'(rand_bits(16));
    return w;
  endfunction

  // Tile outputs from active words, relaxed until chains settle
  function automatic logic [3:0] model_out(input logic [3:0] fin, input logic [3:0] ff_vals);
    logic [3:0]  outs;
    logic [7:0]  src;
    logic [3:0]  idx;
    logic [31:0] w;
    outs = '0;
    for (int p = 0; p < 4; p++) begin
      for (int t = 0; t < 4; t++) begin
        w   = active_m[t];
        src = {outs, fin};
        for (int k = 0; k < 4; k++) begin
          idx[k] = src[w[16 + 3 * k +: 3]];
        end
        outs[t] = w[28] ? ff_vals[t] : w[idx];
      end
    end
    return outs;
  endfunction

  // Inputs change on the falling edge, ack sampled there too
  task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat);
    @(negedge clk);
    wbs_cyc_i = 1'b1;
    wbs_stb_i = 1'b1;
    wbs_we_i  = 1'b1;
    wbs_adr_i = adr;
    wbs_dat_i = dat;
    ack_wait  = 0;
    do begin
      @(negedge clk);
      ack_wait++;
    end while (!wbs_ack_o);
    wbs_cyc_i = 1'b0;
    wbs_stb_i = 1'b0;
    wbs_we_i  = 1'b0;
  endtask

  task automatic wb_read(input logic [31:0] adr, output logic [31:0] dat);
    @(negedge clk);
    wbs_cyc_i = 1'b1;
    wbs_stb_i = 1'b1;
    wbs_we_i  = 1'b0;
    wbs_adr_i = adr;
    do begin
      @(negedge clk);
    end while (!wbs_ack_o);
    dat       = wbs_dat_o;
    wbs_cyc_i = 1'b0;
    wbs_stb_i = 1'b0;
  endtask

  // New word lands in tile 0, older ones move up
  task automatic push_word(input logic [31:0] w);
    wb_write(32'(REG_CFG_DATA), w);
    for (int t = 3; t > 0; t--) begin
      shadow_m[t] = shadow_m[t - 1];
    end
    shadow_m[0] = w;
  endtask

  task automatic apply_set();
    wb_write(32'(REG_CTRL), {30'd0, 1'b1, en_m});
    for (int t = 0; t < 4; t++) begin
      active_m[t] = shadow_m[t];
    end
  endtask

  task automatic drive_and_check(input logic [3:0] fin, input logic [3:0] ff_vals);
    logic [31:0] rd;
    logic [3:0]  exp;
    wb_write(32'(REG_FAB_IN), {28'd0, fin});
    wb_read(32'(REG_FAB_OUT), rd);
    exp = model_out(fin, ff_vals);
    check(rd, {28'd0, exp}, "FAB_OUT vs model");
    check({28'd0, fab_out_o}, {28'd0, exp}, "fab_out_o vs model");
  endtask

  task automatic test_reset_values();
    logic [31:0] rd;
    wb_read(32'(REG_CTRL), rd);
    check(rd, 0, "CTRL after reset");
    wb_read(32'(REG_FAB_IN), rd);
    check(rd, 0, "FAB_IN after reset");
    wb_read(32'(REG_FAB_OUT), rd);
    check(rd, 0, "FAB_OUT after reset");
    check({28'd0, fab_out_o}, 0, "fab_out_o after reset");
    wb_read(32'(REG_CFG_DATA), rd);
    check(rd, 0, "CFG_DATA read");
  endtask

  task automatic test_reg_readback();
    logic [31:0] rd;
    wb_write(32'(REG_FAB_IN), 32'hDEAD_BEE5);
    wb_read(32'(REG_FAB_IN), rd);
    check(rd, 32'h5, "FAB_IN low bits");
    // Upper address bits ignored
    wb_read(32'h3000_0000 | 32'(REG_FAB_IN), rd);
    check(rd, 32'h5, "FAB_IN alias");
    wb_write(32'(REG_CTRL), 32'h1);
    wb_read(32'(REG_CTRL), rd);
    check(rd, 32'h1, "enable set");
    wb_write(32'(REG_CTRL), 32'h0);
    wb_read(32'(REG_CTRL), rd);
    check(rd, 32'h0, "enable clear");
    en_m = 1'b0;
  endtask

  task automatic test_comb_config();
    for (int t = 0; t < 4; t++) begin
      push_word(comb_word());
    end
    apply_set();
    for (int i = 0; i < 20; i++) begin
      drive_and_check(4'(rand_bits(4)), 4'h0);
    end
  endtask

  task automatic test_backpressure();
    logic [31:0] rd;
    push_word(comb_word());
    wb_read(32'(REG_CTRL), rd);
    check(32'(rd[CTRL_BUSY_BIT]), 1, "busy during shift");
    push_word(comb_word());
    // Ack held until the first word is out
    check(32'(ack_wait >= 20), 1, "second write back-pressured");
    wb_read(32'(REG_CTRL), rd);
    check(32'(rd[CTRL_BUSY_BIT]), 1, "busy during second shift");
    // Second word needs one full shift
    repeat (32) @(negedge clk);
    wb_read(32'(REG_CTRL), rd);
    check(32'(rd[CTRL_BUSY_BIT]), 0, "busy after shift");
    apply_set();
    for (int i = 0; i < 6; i++) begin
      drive_and_check(4'(rand_bits(4)), 4'h0);
    end
  endtask

  task automatic test_shadow_isolation();
    for (int t = 0; t < 4; t++) begin
      push_word(comb_word());
    end
    // Active words untouched until set
    for (int i = 0; i < 4; i++) begin
      drive_and_check(4'(rand_bits(4)), 4'h0);
    end
    apply_set();
    for (int i = 0; i < 4; i++) begin
      drive_and_check(4'(rand_bits(4)), 4'h0);
    end
  endtask

  task automatic test_registered();
    logic [31:0] w1;
    logic [31:0] rd;
    // Tile 1 reads tile 0 on LUT input 0
    w1 = comb_word();
    w1[18:16] = 3'd4;
    push_word(comb_word());
    push_word(comb_word());
    push_word(w1);
    // Tile 0 registered, output follows index bit 0
    push_word({3'd0, 1'b1, 12'd0, 16'hAAAA});
    apply_set();
    drive_and_check(4'hF, 4'h0);
    check(32'(fab_out_o[0]), 0, "tile 0 holds with enable low");
    wb_write(32'(REG_CTRL), 32'h1);
    en_m = 1'b1;
    repeat (2) @(negedge clk);
    wb_read(32'(REG_FAB_OUT), rd);
    check(32'(rd[0]), 1, "tile 0 loads input");
    check(rd, {28'd0, model_out(4'hF, 4'h1)}, "tile 1 after tile 0 loads");
    wb_write(32'(REG_FAB_IN), 32'hE);
    repeat (2) @(negedge clk);
    wb_read(32'(REG_FAB_OUT), rd);
    check(rd, {28'd0, model_out(4'hE, 4'h0)}, "tile 0 reloads zero");
    wb_write(32'(REG_CTRL), 32'h0);
    en_m = 1'b0;
  endtask

  initial begin
    rst_n_i   = 1'b0;
    wbs_cyc_i = 1'b0;
    wbs_stb_i = 1'b0;
    wbs_we_i  = 1'b0;
    wbs_sel_i = 4'hF;
    wbs_adr_i = '0;
    wbs_dat_i = '0;
    lfsr_q    = 16'd2;
    cycle_cnt = 0;
    ack_wait  = 0;
    en_m      = 1'b0;
    for (int t = 0; t < 4; t++) begin
      shadow_m[t] = '0;
      active_m[t] = '0;
    end
    repeat (8) @(negedge clk);
    rst_n_i = 1'b1;
    test_reset_values();
    test_reg_readback();
    test_comb_config();
    test_backpressure();
    test_shadow_isolation();
    test_registered();
    $display("All checks passed");
    $finish;
  end

endmodule

/* sources.f */
rtl/fabric_pkg.sv
rtl/wb_map_pkg.sv
rtl/wb_config_ctrl.sv
rtl/config_segment.sv
rtl/logic_cell.sv
rtl/fabric_top.sv
verif/tb_clk_gen.sv
verif/tb_fabric_top.sv

/* Bender.yml */
package:
  name: fabric_top

sources:
  - rtl/fabric_pkg.sv
  - rtl/wb_map_pkg.sv
  - rtl/wb_config_ctrl.sv
  - rtl/config_segment.sv
  - rtl/logic_cell.sv
  - rtl/fabric_top.sv
  - target: simulation
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_fabric_top.sv
